//--- common/rv_pkg.sv
package rv_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_imm   = 7'b0010011,           // OP-IMM, incl. shifts
        op_reg   = 7'b0110011,           // OP, register-register
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_e;

    // ALU operations, low values follow the func3 order
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10               // lui, operand b straight through
    } alu_op_e;

    // decoder control bundle, 30 bits
    typedef struct packed {
        alu_op_e     alu_op;
        logic        src_a_pc;           // operand a = pc
        logic        src_b_imm;          // operand b = immediate
        logic        reg_write;
        logic        is_branch;
        logic        is_jump;            // jal and jalr
        logic        is_jalr;
        logic        is_load;
        logic        is_store;
        logic [2:0]  func3;              // branch condition select
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
    } decode_t;

    // registered result record, 137 bits
    typedef struct packed {
        logic [4:0]  rd;
        logic        reg_write;
        logic [31:0] wdata;
        logic        redirect;           // jump or taken branch
        logic [31:0] target;
        logic        mem_en;             // load or store
        logic        mem_we;             // store only
        logic [31:0] mem_addr;
        logic [31:0] store_data;
    } exec_result_t;

endpackage

//--- files.f
common/rv_pkg.sv
hw/imm_gen.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/rv_exec_top.sv
verif/tb_rv_exec_top.sv

//--- hw/execute_unit.sv
module execute_unit import rv_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         instr_valid,
    input  logic [31:0]  pc,
    input  decode_t      ctrl,
    input  logic [31:0]  imm,
    input  logic [31:0]  rs1_data,
    input  logic [31:0]  rs2_data,
    output logic         res_valid,
    output exec_result_t res
);

    logic [31:0]  op_a;
    logic [31:0]  op_b;
    logic [31:0]  alu_res;
    logic         taken;                 // branch condition met
    exec_result_t nxt;

    assign op_a = ctrl.src_a_pc  ? pc  : rs1_data;
    assign op_b = ctrl.src_b_imm ? imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_sll:    alu_res = op_a << op_b[4:0];
            alu_slt:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_res = {31'b0, op_a < op_b};
            alu_xor:    alu_res = op_a ^ op_b;
            alu_srl:    alu_res = op_a >> op_b[4:0];
            alu_sra:    alu_res = $signed(op_a) >>> op_b[4:0];
            alu_or:     alu_res = op_a | op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_pass_b: alu_res = op_b;   // lui
            default:    alu_res = 32'b0;
        endcase
    end

    // branch compare uses the registers since the alu holds pc + imm
    always_comb begin
        case (ctrl.func3)
            3'b000:  taken = (rs1_data == rs2_data);                   // beq
            3'b001:  taken = (rs1_data != rs2_data);                   // bne
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));  // blt
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110:  taken = (rs1_data < rs2_data);                    // bltu
            3'b111:  taken = (rs1_data >= rs2_data);                   // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        nxt            = '0;
        nxt.rd         = ctrl.rd;
        nxt.reg_write  = ctrl.reg_write;
        nxt.wdata      = ctrl.is_jump ? pc + 32'd4 : alu_res;  // link value
        nxt.redirect   = ctrl.is_jump || (ctrl.is_branch && taken);
        if (ctrl.is_jump || ctrl.is_branch) begin
            nxt.target = {alu_res[31:1], alu_res[0] & ~ctrl.is_jalr};  // jalr clears bit 0
        end
        nxt.mem_en     = ctrl.is_load || ctrl.is_store;
        nxt.mem_we     = ctrl.is_store;
        if (nxt.mem_en) begin
            nxt.mem_addr = alu_res;      // rs1 + imm
        end
        if (ctrl.is_store) begin
            nxt.store_data = rs2_data;
        end
    end

    // record only lives for the pulse cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res       <= '0;
        end else begin
            res_valid <= instr_valid;
            res       <= instr_valid ? nxt : '0;
        end
    end

    // a jump or taken branch never also accesses memory
    a_redirect_no_mem: assert property (
        @(posedge clk) disable iff (!rst_n) res_valid |-> !(res.redirect && res.mem_en)
    );

endmodule

//--- hw/imm_gen.sv
module imm_gen import rv_pkg::*; (
    input  logic        clk,             // assertion sampling only
    input  logic [31:0] instr,
    output logic [31:0] imm
);

    opcode_e    opc;
    logic [2:0] func3;

    assign opc   = opcode_e'(instr[6:0]);
    assign func3 = instr[14:12];

    always_comb begin
        imm = 32'b0;                     // unsupported opcodes give zero
        case (opc)
            op_load, op_jalr: begin      // plain I-type
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            op_imm: begin
                if (func3 == 3'b001 || func3 == 3'b101) begin
                    imm = {27'b0, instr[24:20]};  // shamt only with func7 dropped
                end else begin
                    imm = {{20{instr[31]}}, instr[31:20]};
                end
            end
            op_store: begin              // S-type split field
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            op_branch: begin             // B-type halfword offset
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            op_jal: begin                // J-type
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            op_lui, op_auipc: begin      // U-type in the upper 20 bits
                imm = {instr[31:12], 12'b0};
            end
            default: begin
                imm = 32'b0;
            end
        endcase
    end

    // func7 is dropped on shifts so only slli, srli and srai encodings may arrive
    a_shift_func7_legal: assert property (
        @(posedge clk) (opc == op_imm && (func3 == 3'b001 || func3 == 3'b101)) |->
            (instr[31:25] == 7'b0 || (func3 == 3'b101 && instr[31:25] == 7'b0100000))
    );

endmodule

//--- hw/instr_decoder.sv
module instr_decoder import rv_pkg::*; (
    input  logic [31:0] instr,
    output decode_t     ctrl
);

    opcode_e    opc;
    logic [2:0] func3;
    logic       f7_alt;                  // func7 bit 5, sub / sra

    assign opc    = opcode_e'(instr[6:0]);
    assign func3  = instr[14:12];
    assign f7_alt = instr[30];

    // func3 to alu op, alt picks sub / sra
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl = '0;                       // unknown opcode, all-zero bundle
        if (opc inside {op_load, op_store, op_branch, op_jal, op_jalr,
                        op_imm, op_reg, op_lui, op_auipc}) begin
            ctrl.func3 = func3;
            ctrl.rd    = instr[11:7];
            ctrl.rs1   = instr[19:15];
            ctrl.rs2   = instr[24:20];
        end
        case (opc)
            op_reg: begin
                ctrl.alu_op    = alu_from_f3(func3, f7_alt);
                ctrl.reg_write = 1'b1;
            end
            op_imm: begin                // no subi, alt only for srai
                ctrl.alu_op    = alu_from_f3(func3, f7_alt && func3 == 3'b101);
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_lui: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_auipc, op_jal: begin      // pc + imm
                ctrl.alu_op    = alu_add;
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.is_jump   = (opc == op_jal);
            end
            op_jalr: begin               // rs1 + imm
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.is_jump   = 1'b1;
                ctrl.is_jalr   = 1'b1;
            end
            op_branch: begin             // alu forms the target
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.is_branch = 1'b1;
            end
            op_load, op_store: begin     // address gen, no writeback
                ctrl.src_b_imm = 1'b1;
                ctrl.is_load   = (opc == op_load);
                ctrl.is_store  = (opc == op_store);
            end
            default: ;
        endcase
    end

endmodule

//--- hw/reg_file.sv
module reg_file import rv_pkg::*; #(
    parameter int reg_count = 32         // 16 for rv32e
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [4:0]   rs1,
    input  logic [4:0]   rs2,
    output logic [31:0]  rs1_data,
    output logic [31:0]  rs2_data,
    input  logic         wr_valid,
    input  exec_result_t wr_rec
);

    localparam int aw = $clog2(reg_count);

    logic [31:0] regs [reg_count];
    logic        wr_en;

    // single place the writeback condition is formed
    assign wr_en = wr_valid && wr_rec.reg_write && (wr_rec.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_rec.rd[aw-1:0]] <= wr_rec.wdata;
        end
    end

    // read with write-through, x0 forced to zero
    always_comb begin
        rs1_data = (rs1 == 5'd0) ? 32'b0 : regs[rs1[aw-1:0]];
        rs2_data = (rs2 == 5'd0) ? 32'b0 : regs[rs2[aw-1:0]];
        if (wr_en && wr_rec.rd == rs1) rs1_data = wr_rec.wdata;  // bypass
        if (wr_en && wr_rec.rd == rs2) rs2_data = wr_rec.wdata;
    end

    // x0 stays zero across all writebacks
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == 32'b0);

endmodule

//--- hw/rv_exec_top.sv
module rv_exec_top import rv_pkg::*; #(
    parameter int reg_count = 32
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         instr_valid,      // one-cycle strobe
    input  logic [31:0]  instr,
    input  logic [31:0]  pc,
    output logic         res_valid,        // pulse one cycle after strobe
    output exec_result_t res
);

    decode_t     ctrl;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    instr_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    imm_gen u_imm (
        .clk   (clk),
        .instr (instr),
        .imm   (imm)
    );

    reg_file #(.reg_count(reg_count)) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_valid (res_valid),              // writeback from the record
        .wr_rec   (res)
    );

    execute_unit u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .pc          (pc),
        .ctrl        (ctrl),
        .imm         (imm),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .res_valid   (res_valid),
        .res         (res)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the rv_exec_top testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f files.f --top-module tb_rv_exec_top -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\* PASS \*\*' <<< "$out"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- verif/tb_rv_exec_top.sv
module tb_rv_exec_top import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic [31:0]  instr;
        logic [31:0]  pc;
        exec_result_t exp;
        logic         chk_tgt;           // target defined for jump or branch
    } entry_t;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         instr_valid;
    logic [31:0]  instr;
    logic [31:0]  pc;
    logic         res_valid;
    exec_result_t res;

    entry_t      tbl[$];
    logic [31:0] mregs [32];             // model copy of the register file
    logic [31:0] pc_next;
    int          errors = 0;
    int          checks = 0;
    int          cur_idx = 0;
    bit          timed_out = 1'b0;

    rv_exec_top #(.reg_count(32)) u_dut (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .res_valid(res_valid), .res(res)
    );

    always #50 clk = ~clk;               // 100 ns period

    function automatic logic [31:0] enc_i(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};  // also r-type with imm as {func7, rs2}
    endfunction

    function automatic logic [31:0] enc_s(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_u(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic logic [4:0] rnd_reg();
        return 5'(1 + ($urandom % 31));  // x1..x31
    endfunction

    // rv32i integer result by func3 with alt for sub and sra
    function automatic logic [31:0] alu(logic [2:0] f3, logic alt, logic [31:0] a, logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // reference model for one instruction that appends the expected record
    task automatic add_entry(input logic [31:0] ins);
        entry_t      e;
        logic [31:0] a, b, i_imm, s_imm, b_imm, j_imm, u_imm;
        logic [2:0]  f3;
        logic        shift;
        f3    = ins[14:12];
        a     = mregs[ins[19:15]];
        b     = mregs[ins[24:20]];
        shift = (f3 == 3'd1 || f3 == 3'd5);
        i_imm = {{20{ins[31]}}, ins[31:20]};
        s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        u_imm = {ins[31:12], 12'b0};
        e.instr = ins;
        e.pc = pc_next;
        e.exp = '0;
        e.chk_tgt = 1'b0;
        e.exp.rd = ins[11:7];
        case (ins[6:0])
            op_imm: e.exp.wdata = alu(f3, shift && ins[30], a, shift ? {27'b0, ins[24:20]} : i_imm);
            op_reg: e.exp.wdata = alu(f3, ins[30], a, b);
            op_lui: e.exp.wdata = u_imm;
            op_auipc: e.exp.wdata = pc_next + u_imm;
            op_jal: e.exp.target = pc_next + j_imm;
            op_jalr: e.exp.target = (a + i_imm) & ~32'd1;   // lsb dropped
            op_branch: begin
                e.exp.target = pc_next + b_imm;
                case (f3)
                    3'd0: e.exp.redirect = (a == b);
                    3'd1: e.exp.redirect = (a != b);
                    3'd4: e.exp.redirect = ($signed(a) < $signed(b));
                    3'd5: e.exp.redirect = ($signed(a) >= $signed(b));
                    3'd6: e.exp.redirect = (a < b);
                    default: e.exp.redirect = (a >= b);
                endcase
            end
            op_load: e.exp.mem_addr = a + i_imm;
            op_store: e.exp.mem_addr = a + s_imm;
            default: e.exp.rd = 5'd0;    // unsupported opcode gives an empty record
        endcase
        e.exp.reg_write = ins[6:0] inside {op_imm, op_reg, op_lui, op_auipc, op_jal, op_jalr};
        e.chk_tgt = ins[6:0] inside {op_jal, op_jalr, op_branch};
        e.exp.mem_en = ins[6:0] inside {op_load, op_store};
        e.exp.mem_we = (ins[6:0] == op_store);
        if (ins[6:0] == op_jal || ins[6:0] == op_jalr) begin
            e.exp.wdata = pc_next + 32'd4;    // link address
            e.exp.redirect = 1'b1;
        end
        if (e.exp.mem_we) e.exp.store_data = b;
        if (e.exp.reg_write && e.exp.rd != 5'd0) mregs[e.exp.rd] = e.exp.wdata;
        tbl.push_back(e);
        pc_next = pc_next + 32'd4;
    endtask

    task automatic build_table();
        logic [2:0] br_f3 [6];
        logic [4:0] pair_a [3];
        logic [4:0] pair_b [3];
        br_f3  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        pair_a = '{5'd10, 5'd12, 5'd13};   // equal, signed lt, unsigned lt
        pair_b = '{5'd11, 5'd13, 5'd12};
        foreach (mregs[i]) mregs[i] = '0;
        pc_next = 32'h0000_1000;
        add_entry(enc_i(op_imm, 3'd0, 5'd1, 5'd0, 12'hf9c));     // addi x1, x0, -100
        add_entry(enc_i(op_imm, 3'd0, 5'd2, 5'd1, 12'd37));      // -63
        add_entry(enc_i(op_imm, 3'd5, 5'd3, 5'd2, 12'h403));     // srai on negative
        add_entry(enc_i(op_imm, 3'd5, 5'd4, 5'd3, 12'h003));     // srli
        add_entry(enc_i(op_imm, 3'd4, 5'd5, 5'd4, 12'h5a5));     // xori
        add_entry(enc_i(op_imm, 3'd6, 5'd6, 5'd5, 12'h0f0));     // ori
        add_entry(enc_i(op_imm, 3'd7, 5'd7, 5'd6, 12'h7ff));     // andi
        add_entry(enc_i(op_imm, 3'd1, 5'd8, 5'd7, 12'h004));     // slli
        add_entry(enc_i(op_reg, 3'd0, 5'd9, 5'd8, {7'h00, 5'd3}));   // add
        add_entry(enc_i(op_reg, 3'd0, 5'd10, 5'd9, {7'h20, 5'd2}));  // sub
        repeat (4) add_entry(enc_i(op_imm, 3'd0, rnd_reg(), rnd_reg(), 12'($urandom)));
        repeat (3) begin
            add_entry(enc_u(op_lui, rnd_reg(), 20'($urandom)));
            add_entry(enc_u(op_auipc, rnd_reg(), 20'($urandom)));
        end
        repeat (2) add_entry(enc_j(rnd_reg(), {20'($urandom), 1'b0}));
        // odd rs1 + imm so the jalr target has to drop bit 0
        repeat (2) add_entry(enc_i(op_jalr, 3'd0, rnd_reg(), 5'd1,
                                   {11'($urandom), ~mregs[1][0]}));
        add_entry(enc_i(op_imm, 3'd0, 5'd10, 5'd0, 12'd5));      // branch operands
        add_entry(enc_i(op_imm, 3'd0, 5'd11, 5'd0, 12'd5));
        add_entry(enc_i(op_imm, 3'd0, 5'd12, 5'd0, 12'hffd));    // -3
        add_entry(enc_i(op_imm, 3'd0, 5'd13, 5'd0, 12'd7));
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                add_entry(enc_b(br_f3[f], pair_a[p], pair_b[p], {12'($urandom), 1'b0}));
            end
        end
        add_entry(enc_i(op_load, 3'd2, 5'd14, 5'd13, 12'hff8));  // lw -8(x13)
        add_entry(enc_i(op_load, 3'd2, 5'd15, 5'd12, 12'd100));
        add_entry(enc_s(3'd2, 5'd13, 5'd12, 12'hffc));           // sw x12, -4(x13)
        add_entry(enc_s(3'd2, 5'd12, 5'd10, 12'd2000));
        add_entry(enc_i(op_imm, 3'd0, 5'd0, 5'd13, 12'd9));      // write to x0 is dropped
        add_entry(enc_i(op_reg, 3'd0, 5'd16, 5'd0, {7'h00, 5'd0}));
        add_entry({25'($urandom), 7'b1111111});                  // unsupported opcodes
        add_entry(32'h0000_0000);
        add_entry(enc_i(op_reg, 3'd0, 5'd17, 5'd0, {7'h00, 5'd13}));
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s (entry %0d) got=%h exp=%h", $time, name, cur_idx, got, exp);
        end
    endtask

    task automatic check_entry(input int k);
        exec_result_t x;
        x = tbl[k].exp;
        check_val("res.reg_write", 32'(res.reg_write), 32'(x.reg_write));
        check_val("res.redirect", 32'(res.redirect), 32'(x.redirect));
        check_val("res.mem_en", 32'(res.mem_en), 32'(x.mem_en));
        check_val("res.mem_we", 32'(res.mem_we), 32'(x.mem_we));
        if (x.reg_write) check_val("res.rd", 32'(res.rd), 32'(x.rd));
        if (x.reg_write) check_val("res.wdata", res.wdata, x.wdata);
        if (tbl[k].chk_tgt) check_val("res.target", res.target, x.target);
        if (x.mem_en) check_val("res.mem_addr", res.mem_addr, x.mem_addr);
        if (x.mem_we) check_val("res.store_data", res.store_data, x.store_data);
    endtask

    // pulse expected on the first falling edge after capture
    task automatic wait_result(input int k);
        int cyc;
        cyc = 0;
        cur_idx = k;
        do begin
            @(negedge clk);
            cyc++;
        end while (!res_valid && cyc < 20);
        if (!res_valid) begin
            $display("ERROR: no result after instruction %0d", k);
            errors++;
            timed_out = 1'b1;
        end else begin
            check_val("latency", 32'(cyc), 32'd1);
            check_entry(k);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        void'($urandom(85970));
        build_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("res_valid", 32'(res_valid), 32'd0);   // record cleared by reset
        check_val("res", 32'(|res), 32'd0);
        for (int i = 0; i <= tbl.size() && !timed_out; i++) begin
            @(posedge clk);
            if (i < tbl.size()) begin    // back to back at one per cycle
                instr_valid <= 1'b1;
                instr <= tbl[i].instr;
                pc <= tbl[i].pc;
            end else begin
                instr_valid <= 1'b0;
            end
            if (i > 0) wait_result(i - 1);
        end
        if (!timed_out) begin
            @(negedge clk);
            check_val("res_valid", 32'(res_valid), 32'd0);   // last pulse ends
        end
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
